/* sources.f */
+incdir+hdl
hdl/tsp_pkg.sv
hdl/ts_packet_aligner.sv
hdl/tsp_host_regs.sv
hdl/pid_drop_filter.sv
hdl/pid_replacer.sv
hdl/ts_output_merger.sv
hdl/ts_pid_processor.sv
sim/ts_pid_processor_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ts_pid_processor_tb
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: sim clean

# the run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

/* sim/ts_pid_processor_tb.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module ts_pid_processor_tb;
	import tsp_pkg::*;

	localparam logic [1:0] ACT_PASS = 2'd0;
	localparam logic [1:0] ACT_DROP = 2'd1;
	localparam logic [1:0] ACT_REPL0 = 2'd2;
	localparam logic [1:0] ACT_REPL1 = 2'd3;
	localparam int ROWS = 10;
	localparam int TIMEOUT_CYCLES = 3 * ROWS * `TSP_PACK_BYTES * 4 +
		8 * (`TSP_REPL_ENTRIES * `TSP_PACK_BYTES + 32) + 2000;

	typedef struct packed {
		pid_t pid;
		logic [1:0] act_cfg;
		logic [1:0] act_recfg;
	} row_t;

	typedef struct packed {
		ts_byte_t data;
		logic sync;
		byte_idx_t idx;
		logic [7:0] row;
	} exp_beat_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table and table setup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam row_t STIM [ROWS] = '{
		'{13'h0011, ACT_PASS, ACT_PASS},
		'{13'h0100, ACT_DROP, ACT_DROP},
		'{13'h0500, ACT_REPL0, ACT_REPL0},
		'{13'h0300, ACT_DROP, ACT_REPL1}, // in both tables until drop entry 2 is switched off.
		'{13'h0700, ACT_PASS, ACT_PASS}, // drop entry 3 holds this pid but stays disabled.
		'{13'h0200, ACT_DROP, ACT_DROP},
		'{13'h1fff, ACT_PASS, ACT_PASS},
		'{13'h0100, ACT_DROP, ACT_DROP},
		'{13'h0300, ACT_DROP, ACT_REPL1},
		'{13'h0500, ACT_REPL0, ACT_REPL0}
	};
	localparam pid_t DROP_PID [`TSP_DROP_ENTRIES] = '{13'h0100, 13'h0200, 13'h0300, 13'h0700};
	localparam logic [`TSP_DROP_ENTRIES-1:0] DROP_EN = 4'b0111;
	localparam pid_t REPL_PID [`TSP_REPL_ENTRIES] = '{13'h0500, 13'h0300};

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	ts_beat_t ts_in;
	ts_beat_t ts_out;
	host_req_t host_req;
	host_rsp_t host_rsp;
	int seed;
	int cycles = 0;
	exp_beat_t exp_q [$];
	logic [`TSP_DROP_ENTRIES-1:0] drop_en_model;
	int exp_cnt [`TSP_DROP_ENTRIES];

	ts_pid_processor i_ts_pid_processor (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_in         (ts_in),
		.ts_out        (ts_out),
		.host_req      (host_req),
		.host_rsp      (host_rsp)
	);

	initial begin
		mpeg_clk = 1'b0;
		forever #2 mpeg_clk = ~mpeg_clk;
	end

	always @(posedge mpeg_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles before all packets came out", cycles));
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic ts_byte_t stored_byte(input int entry, input int idx);
		return ts_byte_t'((entry * 64 + idx) % 256);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host port driver
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic host_access(input logic write, input host_addr_t addr,
			input host_data_t wdata, output host_data_t rdata);
		host_req = '{req: 1'b1, we: write, addr: addr, wdata: wdata};
		do begin
			@(posedge mpeg_clk);
			#1;
		end while (!host_rsp.ack);
		rdata = host_rsp.rdata; // read data holds while ack is high.
		host_req.req = 1'b0;
		do begin
			@(posedge mpeg_clk);
			#1;
		end while (host_rsp.ack);
	endtask

	task automatic host_write(input host_addr_t addr, input host_data_t wdata);
		host_data_t unused;
		host_access(1'b1, addr, wdata, unused);
	endtask

	task automatic host_read(input host_addr_t addr, output host_data_t rdata);
		host_access(1'b0, addr, '0, rdata);
	endtask

	task automatic write_entry(input host_addr_t base, input int idx, input pid_t pid,
			input logic en);
		host_data_t word;
		word = '0;
		word[`TSP_ENTRY_EN_BIT] = en;
		word[`TSP_PID_BITS-1:0] = pid;
		host_write(base + host_addr_t'(idx), word);
	endtask

	task automatic load_config();
		for (int d = 0; d < `TSP_DROP_ENTRIES; d++) begin
			write_entry(`TSP_ADDR_DROP_BASE, d, DROP_PID[d], DROP_EN[d]);
		end
		drop_en_model = DROP_EN;
		for (int r = 0; r < `TSP_REPL_ENTRIES; r++) begin
			write_entry(`TSP_ADDR_REPL_BASE, r, REPL_PID[r], 1'b1);
			for (int i = 0; i < `TSP_PACK_BYTES; i++) begin
				host_write(host_addr_t'(`TSP_ADDR_RDATA_BASE + (r << `TSP_RDATA_ENTRY_BIT) + i),
					host_data_t'(stored_byte(r, i)));
			end
		end
	endtask

	// counter 0 is read last so a later read starts from a nonzero value.
	task automatic check_counters();
		host_data_t rd;
		for (int d = `TSP_DROP_ENTRIES - 1; d >= 0; d--) begin
			host_read(host_addr_t'(`TSP_ADDR_CNT_BASE + d), rd);
			assert (rd == host_data_t'(exp_cnt[d]))
			else abort_run($sformatf("[FAIL] %0t ns: drop counter %0d reads %0d, expected %0d",
				$time, d, rd, exp_cnt[d]));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stream driver
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic send_byte(input ts_byte_t value, input logic first);
		ts_in = '{data: value, sync: first, valid: 1'b1};
		@(posedge mpeg_clk);
		#1;
		ts_in.valid = 1'b0;
		ts_in.sync = 1'b0;
		repeat (3) begin
			@(posedge mpeg_clk);
			#1;
		end
	endtask

	task automatic send_packet(input int row, input int phase);
		ts_byte_t pkt_q [$];
		logic [1:0] act;
		pid_t pid;
		exp_beat_t e;
		pid = STIM[row].pid;
		act = (phase == 0) ? ACT_PASS : (phase == 1) ? STIM[row].act_cfg : STIM[row].act_recfg;
		pkt_q.push_back(8'h47);
		pkt_q.push_back({3'b000, pid[12:8]});
		pkt_q.push_back(pid[7:0]);
		while (pkt_q.size() < `TSP_PACK_BYTES) begin
			pkt_q.push_back(ts_byte_t'($random(seed)));
		end
		for (int d = 0; d < `TSP_DROP_ENTRIES; d++) begin
			if (drop_en_model[d] && DROP_PID[d] == pid) begin
				exp_cnt[d]++;
			end
		end
		if (act != ACT_DROP) begin
			for (int i = 0; i < `TSP_PACK_BYTES; i++) begin
				e.data = (act == ACT_PASS) ? pkt_q[i] :
					stored_byte(int'(act) - int'(ACT_REPL0), i);
				e.sync = (i == 0);
				e.idx = byte_idx_t'(i);
				e.row = 8'(row);
				exp_q.push_back(e);
			end
		end
		for (int i = 0; i < `TSP_PACK_BYTES; i++) begin
			send_byte(pkt_q[i], i == 0);
		end
	endtask

	task automatic run_phase(input int phase);
		for (int r = 0; r < ROWS; r++) begin
			send_packet(r, phase);
		end
		send_byte(8'h47, 1'b1); // a padding packet pushes out the last two bytes.
		send_byte(8'h1f, 1'b0);
		send_byte(8'h47, 1'b1); // a sync at byte 2 sends the aligner back to hunt.
		while (exp_q.size() != 0) begin
			@(posedge mpeg_clk);
			#1;
		end
		repeat (8) begin
			@(posedge mpeg_clk);
			#1;
		end
	endtask

	// every output beat must be the next one the model expects.
	always @(negedge mpeg_clk) begin
		exp_beat_t e;
		if (S_AXI_ARESETN && ts_out.valid) begin
			assert (exp_q.size() > 0)
			else abort_run($sformatf("an output beat came out at %0t ns with none expected", $time));
			e = exp_q.pop_front();
			assert (ts_out.data == e.data && ts_out.sync == e.sync)
			else abort_run($sformatf(
				"[FAIL] %0t ns: row %0d byte %0d gave %02h sync %0b, expected %02h sync %0b",
				$time, e.row, e.idx, ts_out.data, ts_out.sync, e.data, e.sync));
		end
	end

	initial begin
		host_data_t rd;
		seed = 15477;
		ts_in = '0;
		host_req = '0;
		S_AXI_ARESETN = 1'b0;
		drop_en_model = '0;
		for (int d = 0; d < `TSP_DROP_ENTRIES; d++) begin
			exp_cnt[d] = 0;
		end
		repeat (16) @(posedge mpeg_clk);
		#1;
		S_AXI_ARESETN = 1'b1;
		for (int i = 0; i < 6; i++) begin
			send_byte(ts_byte_t'($random(seed)), 1'b0); // no sync yet so nothing may come out.
		end
		send_byte(8'h47, 1'b0);
		run_phase(0);
		load_config();
		run_phase(1);
		check_counters();
		write_entry(`TSP_ADDR_DROP_BASE, 2, DROP_PID[2], 1'b0);
		drop_en_model[2] = 1'b0;
		run_phase(2);
		check_counters();
		host_read(10'h3f0, rd);
		assert (rd == '0)
		else abort_run($sformatf("[FAIL] %0t ns: unmapped address reads %04h, expected 0000",
			$time, rd));
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* hdl/ts_pid_processor.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module ts_pid_processor (
	input  logic               mpeg_clk,
	input  logic               S_AXI_ARESETN,
	input  tsp_pkg::ts_beat_t  ts_in,
	output tsp_pkg::ts_beat_t  ts_out,
	input  tsp_pkg::host_req_t host_req,
	output tsp_pkg::host_rsp_t host_rsp
);
	import tsp_pkg::*;

	aligned_beat_t beat;
	tbl_wr_t drop_wr;
	tbl_wr_t repl_wr;
	ram_wr_t ram_wr;
	hit_cnt_t [`TSP_DROP_ENTRIES-1:0] hit_cnt;
	logic drop;
	logic replace;
	ts_byte_t repl_byte;

	ts_packet_aligner i_aligner (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_in         (ts_in),
		.beat          (beat)
	);

	tsp_host_regs i_host_regs (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.host_req      (host_req),
		.host_rsp      (host_rsp),
		.drop_wr       (drop_wr),
		.repl_wr       (repl_wr),
		.ram_wr        (ram_wr),
		.hit_cnt       (hit_cnt)
	);

	// both decisions are taken on the same aligned beat.
	pid_drop_filter i_drop_filter (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.beat          (beat),
		.tbl_wr        (drop_wr),
		.drop          (drop),
		.hit_cnt       (hit_cnt)
	);

	pid_replacer i_replacer (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.beat          (beat),
		.tbl_wr        (repl_wr),
		.ram_wr        (ram_wr),
		.replace       (replace),
		.repl_byte     (repl_byte)
	);

	ts_output_merger i_merger (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.beat          (beat),
		.drop          (drop),
		.replace       (replace),
		.repl_byte     (repl_byte),
		.ts_out        (ts_out)
	);

endmodule

/* hdl/ts_output_merger.sv */
`timescale 1ns/10ps

module ts_output_merger (
	input  logic                   mpeg_clk,
	input  logic                   S_AXI_ARESETN,
	input  tsp_pkg::aligned_beat_t beat,
	input  logic                   drop,
	input  logic                   replace,
	input  tsp_pkg::ts_byte_t      repl_byte,
	output tsp_pkg::ts_beat_t      ts_out
);
	import tsp_pkg::*;

	logic beat_d_vld;
	logic beat_d_first;
	ts_byte_t beat_d_data;
	logic out_vld;
	logic out_sync;
	ts_byte_t out_data;

	// the delayed beat lines up with the registered drop and replace results.
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			beat_d_vld <= 1'b0;
			out_vld <= 1'b0;
			out_sync <= 1'b0;
		end else begin
			beat_d_vld <= beat.valid;
			out_vld <= beat_d_vld && !drop; // drop beats replace.
			out_sync <= beat_d_vld && beat_d_first && !drop;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		beat_d_data <= beat.data;
		beat_d_first <= beat.byte_idx == '0;
		out_data <= replace ? repl_byte : beat_d_data;
	end

	assign ts_out = '{data: out_data, sync: out_sync, valid: out_vld};

endmodule

/* hdl/pid_replacer.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module pid_replacer (
	input  logic                   mpeg_clk,
	input  logic                   S_AXI_ARESETN,
	input  tsp_pkg::aligned_beat_t beat,
	input  tsp_pkg::tbl_wr_t       tbl_wr,
	input  tsp_pkg::ram_wr_t       ram_wr,
	output logic                   replace,
	output tsp_pkg::ts_byte_t      repl_byte
);
	import tsp_pkg::*;

	pid_t ent_pid [`TSP_REPL_ENTRIES];
	logic [`TSP_REPL_ENTRIES-1:0] ent_en;
	logic [`TSP_REPL_ENTRIES-1:0] hit;
	logic any_hit;
	logic first;
	repl_idx_t sel_new;
	repl_idx_t sel_q;
	repl_idx_t rd_entry;
	ts_byte_t ram [`TSP_REPL_ENTRIES][`TSP_PACK_BYTES];

	assign first = beat.valid && beat.byte_idx == '0;

	always_comb begin
		for (int i = 0; i < `TSP_REPL_ENTRIES; i++) begin
			hit[i] = ent_en[i] && ent_pid[i] == beat.pid;
		end
	end

	// scan downwards so the lowest matching entry is the one kept.
	always_comb begin
		any_hit = 1'b0;
		sel_new = '0;
		for (int i = `TSP_REPL_ENTRIES - 1; i >= 0; i--) begin
			if (hit[i]) begin
				any_hit = 1'b1;
				sel_new = repl_idx_t'(i);
			end
		end
	end

	assign rd_entry = (beat.byte_idx == '0) ? sel_new : sel_q; // byte 0 reads with the new choice.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// entry table and decision
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			ent_en <= '0;
			replace <= 1'b0;
		end else begin
			for (int i = 0; i < `TSP_REPL_ENTRIES; i++) begin
				if (tbl_wr.we && tbl_wr.idx == tbl_idx_t'(i)) begin
					ent_en[i] <= tbl_wr.en;
				end
			end
			if (first) begin
				replace <= any_hit;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		for (int i = 0; i < `TSP_REPL_ENTRIES; i++) begin
			if (tbl_wr.we && tbl_wr.idx == tbl_idx_t'(i)) begin
				ent_pid[i] <= tbl_wr.pid;
			end
		end
		if (first) begin
			sel_q <= sel_new;
		end
	end

	// the replacement packet store is read once per beat.
	always_ff @(posedge mpeg_clk) begin
		if (ram_wr.we) begin
			ram[ram_wr.entry][ram_wr.byte_idx] <= ram_wr.data;
		end
		if (beat.valid) begin
			repl_byte <= ram[rd_entry][beat.byte_idx];
		end
	end

endmodule

/* hdl/pid_drop_filter.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module pid_drop_filter (
	input  logic                                     mpeg_clk,
	input  logic                                     S_AXI_ARESETN,
	input  tsp_pkg::aligned_beat_t                   beat,
	input  tsp_pkg::tbl_wr_t                         tbl_wr,
	output logic                                     drop,
	output tsp_pkg::hit_cnt_t [`TSP_DROP_ENTRIES-1:0] hit_cnt
);
	import tsp_pkg::*;

	pid_t ent_pid [`TSP_DROP_ENTRIES];
	logic [`TSP_DROP_ENTRIES-1:0] ent_en;
	logic [`TSP_DROP_ENTRIES-1:0] hit;
	logic first;

	assign first = beat.valid && beat.byte_idx == '0;

	always_comb begin
		for (int i = 0; i < `TSP_DROP_ENTRIES; i++) begin
			hit[i] = ent_en[i] && ent_pid[i] == beat.pid;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		for (int i = 0; i < `TSP_DROP_ENTRIES; i++) begin
			if (tbl_wr.we && tbl_wr.idx == tbl_idx_t'(i)) begin
				ent_pid[i] <= tbl_wr.pid;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// enables, decision and hit counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			ent_en <= '0;
			drop <= 1'b0;
			hit_cnt <= '0;
		end else begin
			for (int i = 0; i < `TSP_DROP_ENTRIES; i++) begin
				if (tbl_wr.we && tbl_wr.idx == tbl_idx_t'(i)) begin
					ent_en[i] <= tbl_wr.en;
				end
			end
			if (first) begin
				drop <= |hit; // held until the next packet starts.
				for (int i = 0; i < `TSP_DROP_ENTRIES; i++) begin
					if (hit[i] && hit_cnt[i] != '1) begin
						hit_cnt[i] <= hit_cnt[i] + hit_cnt_t'(1);
					end
				end
			end
		end
	end

endmodule

/* hdl/tsp_host_regs.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module tsp_host_regs (
	input  logic                                     mpeg_clk,
	input  logic                                     S_AXI_ARESETN,
	input  tsp_pkg::host_req_t                       host_req,
	output tsp_pkg::host_rsp_t                       host_rsp,
	output tsp_pkg::tbl_wr_t                         drop_wr,
	output tsp_pkg::tbl_wr_t                         repl_wr,
	output tsp_pkg::ram_wr_t                         ram_wr,
	input  tsp_pkg::hit_cnt_t [`TSP_DROP_ENTRIES-1:0] hit_cnt
);
	import tsp_pkg::*;

	logic ack_q;
	host_data_t rdata_q;
	logic access;
	logic wr;
	host_addr_t off_drop;
	host_addr_t off_repl;
	host_addr_t off_cnt;
	host_addr_t off_rdata;
	logic in_drop;
	logic in_repl;
	logic in_cnt;
	logic in_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign access = host_req.req && !ack_q; // one cycle per handshake.
	assign wr = access && host_req.we;

	assign off_drop = host_req.addr - `TSP_ADDR_DROP_BASE;
	assign off_repl = host_req.addr - `TSP_ADDR_REPL_BASE;
	assign off_cnt = host_req.addr - `TSP_ADDR_CNT_BASE;
	assign off_rdata = host_req.addr - `TSP_ADDR_RDATA_BASE;

	assign in_drop = off_drop < `TSP_DROP_ENTRIES;
	assign in_repl = off_repl < `TSP_REPL_ENTRIES;
	assign in_cnt = off_cnt < `TSP_DROP_ENTRIES;
	assign in_rdata = off_rdata < (`TSP_REPL_ENTRIES << `TSP_RDATA_ENTRY_BIT) &&
		off_rdata[`TSP_RDATA_ENTRY_BIT-1:0] < `TSP_PACK_BYTES;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign drop_wr.we = wr && in_drop;
	assign drop_wr.idx = off_drop[$bits(tbl_idx_t)-1:0];
	assign drop_wr.pid = host_req.wdata[$bits(pid_t)-1:0];
	assign drop_wr.en = host_req.wdata[`TSP_ENTRY_EN_BIT];

	assign repl_wr.we = wr && in_repl;
	assign repl_wr.idx = off_repl[$bits(tbl_idx_t)-1:0];
	assign repl_wr.pid = host_req.wdata[$bits(pid_t)-1:0];
	assign repl_wr.en = host_req.wdata[`TSP_ENTRY_EN_BIT];

	assign ram_wr.we = wr && in_rdata;
	assign ram_wr.entry = off_rdata[`TSP_RDATA_ENTRY_BIT +: $bits(repl_idx_t)];
	assign ram_wr.byte_idx = off_rdata[`TSP_RDATA_ENTRY_BIT-1:0];
	assign ram_wr.data = host_req.wdata[$bits(ts_byte_t)-1:0];

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= host_req.req; // rises after req is seen high, falls after it is seen low.
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (access) begin
			if (!host_req.we && in_cnt) begin
				rdata_q <= hit_cnt[off_cnt[$bits(tbl_idx_t)-1:0]];
			end else begin
				rdata_q <= '0;
			end
		end
	end

	assign host_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

/* hdl/ts_packet_aligner.sv */
`timescale 1ns/10ps
`include "tsp_consts.svh"

module ts_packet_aligner (
	input  logic                   mpeg_clk,
	input  logic                   S_AXI_ARESETN,
	input  tsp_pkg::ts_beat_t      ts_in,
	output tsp_pkg::aligned_beat_t beat
);
	import tsp_pkg::*;

	localparam byte_idx_t LAST_IDX = byte_idx_t'(`TSP_PACK_BYTES - 1);
	localparam byte_idx_t PID_IDX = byte_idx_t'(2); // pid is complete once byte 2 is in.

	align_state_t state;
	byte_idx_t pos;
	logic [1:0] sr_vld;
	ts_byte_t sr0;
	ts_byte_t sr1;
	pid_t pid_q;
	pid_t pid_new;
	byte_idx_t out_idx;
	logic start;
	logic bad_sync;
	logic adv;
	logic out_vld;
	ts_byte_t out_data;
	byte_idx_t out_idx_q;
	pid_t out_pid;

	assign start = ts_in.valid && ts_in.sync && state == ST_HUNT;
	assign bad_sync = ts_in.valid && ts_in.sync && state == ST_LOCK && pos != '0;
	assign adv = ts_in.valid && state == ST_LOCK && !bad_sync;

	assign pid_new = {sr0[4:0], ts_in.data}; // low five bits of byte 1, then byte 2.

	// the byte leaving the shift register sits two positions behind the input.
	always_comb begin
		if (pos == '0) begin
			out_idx = LAST_IDX - byte_idx_t'(1);
		end else if (pos == byte_idx_t'(1)) begin
			out_idx = LAST_IDX;
		end else begin
			out_idx = pos - byte_idx_t'(2);
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			state <= ST_HUNT;
			pos <= '0;
			sr_vld <= '0;
			out_vld <= 1'b0;
		end else begin
			out_vld <= adv && sr_vld[1];
			if (start) begin
				state <= ST_LOCK;
				pos <= byte_idx_t'(1);
				sr_vld <= 2'b01;
			end else if (bad_sync) begin
				state <= ST_HUNT; // the broken packet is given up.
				sr_vld <= '0;
			end else if (adv) begin
				pos <= (pos == LAST_IDX) ? '0 : pos + byte_idx_t'(1);
				sr_vld <= {sr_vld[0], 1'b1};
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (start || adv) begin
			sr0 <= ts_in.data;
			sr1 <= sr0;
		end
		if (adv) begin
			out_data <= sr1;
			out_idx_q <= out_idx;
			out_pid <= (pos == PID_IDX) ? pid_new : pid_q;
			if (pos == PID_IDX) begin
				pid_q <= pid_new; // the old pid still covers the tail of the last packet.
			end
		end
	end

	assign beat = '{data: out_data, valid: out_vld, byte_idx: out_idx_q, pid: out_pid};

endmodule

/* hdl/tsp_pkg.sv */
`include "tsp_consts.svh"

package tsp_pkg;

	typedef logic [7:0] ts_byte_t;
	typedef logic [`TSP_PID_BITS-1:0] pid_t;
	typedef logic [7:0] byte_idx_t;
	typedef logic [9:0] host_addr_t;
	typedef logic [15:0] host_data_t;
	typedef logic [`TSP_CNT_BITS-1:0] hit_cnt_t;
	typedef logic [$clog2(`TSP_DROP_ENTRIES)-1:0] tbl_idx_t; // wide enough for either table.
	typedef logic [$clog2(`TSP_REPL_ENTRIES)-1:0] repl_idx_t;

	typedef struct packed {
		ts_byte_t data;
		logic sync;
		logic valid;
	} ts_beat_t;

	typedef struct packed {
		ts_byte_t data;
		logic valid;
		byte_idx_t byte_idx;
		pid_t pid;
	} aligned_beat_t;

	typedef struct packed {
		logic we;
		tbl_idx_t idx;
		pid_t pid;
		logic en;
	} tbl_wr_t;

	typedef struct packed {
		logic we;
		repl_idx_t entry;
		byte_idx_t byte_idx;
		ts_byte_t data;
	} ram_wr_t;

	typedef struct packed {
		logic req;
		logic we;
		host_addr_t addr;
		host_data_t wdata;
	} host_req_t;

	typedef struct packed {
		logic ack;
		host_data_t rdata;
	} host_rsp_t;

	typedef enum logic {
		ST_HUNT,
		ST_LOCK
	} align_state_t;

endpackage

/* hdl/tsp_consts.svh */
`ifndef TSP_CONSTS_SVH
`define TSP_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet and table sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TSP_PACK_BYTES      188
`define TSP_DROP_ENTRIES    4
`define TSP_REPL_ENTRIES    2
`define TSP_CNT_BITS        16
`define TSP_PID_BITS        13

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host register map with one data word per address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TSP_ADDR_DROP_BASE  10'h000
`define TSP_ADDR_REPL_BASE  10'h010
`define TSP_ADDR_CNT_BASE   10'h020
`define TSP_ADDR_RDATA_BASE 10'h200
`define TSP_RDATA_ENTRY_BIT 8 // address bit that selects the replacement entry.
`define TSP_ENTRY_EN_BIT    13 // enable sits just above the pid in an entry word.

`endif
